/* design/dbg_pkg.sv */
package dbg_pkg;

    // Serial line and datapath sizes
    localparam int CLKS_PER_BIT = 8;
    localparam int NB_DATA      = 8;
    localparam int NB_WORD      = 32;
    localparam int IM_BYTES     = 64;   // 16 instructions
    localparam int RB_DEPTH     = 32;
    localparam int DM_DEPTH     = 128;

    localparam int NB_IM_ADDR   = $clog2(IM_BYTES);
    localparam int NB_RB_ADDR   = $clog2(RB_DEPTH);
    localparam int NB_DM_ADDR   = $clog2(DM_DEPTH);
    localparam int NB_TICK      = $clog2(CLKS_PER_BIT);
    localparam int NB_BIT_CNT   = $clog2(NB_DATA);
    localparam int NB_OPCODE    = 4;

    // Host commands
    localparam logic [NB_DATA-1:0] CMD_WRITE_IM     = 8'd1;
    localparam logic [NB_DATA-1:0] CMD_START        = 8'd2;
    localparam logic [NB_DATA-1:0] CMD_STEP_BY_STEP = 8'd3;
    localparam logic [NB_DATA-1:0] CMD_SEND_BR      = 8'd4;
    localparam logic [NB_DATA-1:0] CMD_SEND_MEM     = 8'd5;
    localparam logic [NB_DATA-1:0] CMD_SEND_PC      = 8'd6;
    localparam logic [NB_DATA-1:0] CMD_STEP         = 8'd7;
    localparam logic [NB_DATA-1:0] CMD_CONTINUE     = 8'd8;

    typedef enum logic [3:0] {
        IDLE,
        START_WRITE_IM,
        WRITE_IM,
        READY,
        START,
        STEP_BY_STEP,
        SEND_PC,
        SEND_MEM,
        SEND_BR
    } dbg_state_e;

    localparam logic [NB_OPCODE-1:0] OP_NOP  = 4'd0;
    localparam logic [NB_OPCODE-1:0] OP_ADDI = 4'd1;
    localparam logic [NB_OPCODE-1:0] OP_ADD  = 4'd2;
    localparam logic [NB_OPCODE-1:0] OP_SB   = 4'd3;
    localparam logic [NB_OPCODE-1:0] OP_HALT = 4'd15;

    // Debug unit to core
    typedef struct packed {
        logic                  run;
        logic                  step_flag;
        logic                  step;
        logic                  im_write;
        logic [NB_IM_ADDR-1:0] im_addr;
        logic [NB_DATA-1:0]    im_data;
        logic [NB_RB_ADDR-1:0] rb_addr;
        logic [NB_DM_ADDR-1:0] dm_addr;
    } dbg_core_ctrl_t;

    // Core back to debug unit
    typedef struct packed {
        logic [NB_WORD-1:0] pc;
        logic               halt;
        logic [NB_WORD-1:0] rb_data;
        logic [NB_DATA-1:0] dm_data;
    } dbg_core_stat_t;

endpackage

/* design/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_serial,
    output logic [dbg_pkg::NB_DATA-1:0] o_data,
    output logic                        o_valid
);
    import dbg_pkg::*;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e              state;
    logic [NB_TICK-1:0]     tick;
    logic [NB_BIT_CNT-1:0]  bit_cnt;
    logic [NB_DATA-1:0]     shift;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state   <= RX_IDLE;
            tick    <= '0;
            bit_cnt <= '0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    tick    <= '0;
                    bit_cnt <= '0;
                    if (!i_serial) state <= RX_START;  // Falling edge of start bit
                end
                RX_START: begin
                    tick <= tick + 1'b1;
                    if (tick == NB_TICK'(CLKS_PER_BIT / 2 - 1)) begin
                        tick  <= '0;
                        // Glitch shorter than half a bit goes back to idle
                        state <= i_serial ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    tick <= tick + 1'b1;
                    if (tick == NB_TICK'(CLKS_PER_BIT - 1)) begin
                        tick    <= '0;
                        shift   <= {i_serial, shift[NB_DATA-1:1]};  // LSB first
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == NB_BIT_CNT'(NB_DATA - 1)) state <= RX_STOP;
                    end
                end
                default: begin
                    tick <= tick + 1'b1;
                    if (tick == NB_TICK'(CLKS_PER_BIT - 1)) begin
                        state   <= RX_IDLE;
                        o_valid <= i_serial;  // Framing error drops the byte
                    end
                end
            endcase
        end
    end

    assign o_data = shift;

endmodule

/* design/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_start,
    input  logic [dbg_pkg::NB_DATA-1:0] i_data,
    output logic                        o_serial,
    output logic                        o_done
);
    import dbg_pkg::*;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

    tx_state_e              state;
    logic [NB_TICK-1:0]     tick;
    logic [NB_BIT_CNT-1:0]  bit_cnt;
    logic [NB_DATA-1:0]     shift;
    logic                   bit_end;

    assign bit_end = (tick == NB_TICK'(CLKS_PER_BIT - 1));

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state    <= TX_IDLE;
            tick     <= '0;
            bit_cnt  <= '0;
            o_serial <= 1'b1;
        end else begin
            tick <= bit_end ? '0 : tick + 1'b1;
            case (state)
                TX_IDLE: begin
                    tick     <= '0;
                    bit_cnt  <= '0;
                    o_serial <= 1'b1;
                    if (i_start) begin
                        shift    <= i_data;  // Byte captured at frame start
                        o_serial <= 1'b0;
                        state    <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        o_serial <= shift[0];
                        state    <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        shift   <= shift >> 1;
                        if (bit_cnt == NB_BIT_CNT'(NB_DATA - 1)) begin
                            o_serial <= 1'b1;  // Stop bit
                            state    <= TX_STOP;
                        end else begin
                            o_serial <= shift[1];
                        end
                    end
                end
                default: if (bit_end) state <= TX_IDLE;
            endcase
        end
    end

    // Last cycle of the stop bit
    assign o_done = (state == TX_STOP) && bit_end;

endmodule

/* design/debug_unit.sv */
`timescale 1ns/1ps

module debug_unit (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_rx_valid,
    input  logic [dbg_pkg::NB_DATA-1:0] i_rx_data,
    input  logic                        i_tx_done,
    input  dbg_pkg::dbg_core_stat_t     i_stat,
    output logic                        o_tx_start,
    output logic [dbg_pkg::NB_DATA-1:0] o_tx_data,
    output dbg_pkg::dbg_core_ctrl_t     o_ctrl
);
    import dbg_pkg::*;

    dbg_state_e             state;
    dbg_state_e             next_state;
    logic [NB_IM_ADDR-1:0]  im_addr;    // Load counter
    logic [NB_DATA-1:0]     im_data;
    logic                   im_write;
    logic [NB_DM_ADDR-1:0]  dump_idx;   // Points at the byte to load next
    logic                   ret_step;   // Dump was started by CMD_STEP
    logic                   step;
    logic                   step_cmd;
    logic                   last_done;
    logic                   next_dump;
    logic                   load;

    // Big-endian byte of the selected word, or the memory byte
    function automatic logic [NB_DATA-1:0] dump_byte(input dbg_state_e sec,
                                                     input logic [1:0] sel,
                                                     input dbg_core_stat_t st);
        logic [NB_WORD-1:0] word;
        word = (sec == SEND_PC) ? st.pc : st.rb_data;
        if (sec == SEND_MEM) begin
            return st.dm_data;
        end
        return word[NB_WORD - 1 - sel * NB_DATA -: NB_DATA];
    endfunction

    // Index wraps to zero once the final byte of a section is loaded
    assign last_done = i_tx_done && (dump_idx == '0);
    assign step_cmd  = (state == STEP_BY_STEP) && !ret_step && !i_stat.halt
                       && i_rx_valid && (i_rx_data == CMD_STEP);

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (i_rx_valid) begin
                    case (i_rx_data)
                        CMD_WRITE_IM: next_state = START_WRITE_IM;
                        CMD_SEND_PC:  next_state = SEND_PC;
                        CMD_SEND_MEM: next_state = SEND_MEM;
                        CMD_SEND_BR:  next_state = SEND_BR;
                        default:      next_state = IDLE;
                    endcase
                end
            end
            START_WRITE_IM: next_state = WRITE_IM;
            WRITE_IM: begin
                if (im_write && im_addr == NB_IM_ADDR'(IM_BYTES - 1)) next_state = READY;
            end
            READY: begin
                if (i_rx_valid && i_rx_data == CMD_START) next_state = START;
                if (i_rx_valid && i_rx_data == CMD_STEP_BY_STEP) next_state = STEP_BY_STEP;
            end
            START: if (i_stat.halt) next_state = IDLE;
            STEP_BY_STEP: begin
                if (ret_step) begin
                    if (!step) next_state = SEND_PC;  // Wait out the step cycle
                end else if (i_stat.halt) begin
                    next_state = IDLE;
                end else if (i_rx_valid && i_rx_data == CMD_CONTINUE) begin
                    next_state = START;
                end
            end
            SEND_PC:  if (last_done) next_state = ret_step ? SEND_MEM : IDLE;
            SEND_MEM: if (last_done) next_state = ret_step ? SEND_BR : IDLE;
            SEND_BR:  if (last_done) next_state = ret_step ? STEP_BY_STEP : IDLE;
            default:  next_state = IDLE;
        endcase
    end

    assign next_dump = next_state inside {SEND_PC, SEND_MEM, SEND_BR};
    // Load on section entry and after every done that is not the last
    assign load      = next_dump && ((next_state != state) || i_tx_done);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state      <= IDLE;
            im_addr    <= '0;
            im_write   <= 1'b0;
            dump_idx   <= '0;
            ret_step   <= 1'b0;
            step       <= 1'b0;
            o_tx_start <= 1'b0;
        end else begin
            state      <= next_state;
            im_write   <= 1'b0;
            step       <= step_cmd;
            o_tx_start <= next_dump;  // Falls with the last done

            if (state == START_WRITE_IM) im_addr <= '0;
            if (state == WRITE_IM) begin
                if (im_write) begin
                    im_addr <= im_addr + 1'b1;
                end else if (i_rx_valid) begin
                    im_write <= 1'b1;
                    im_data  <= i_rx_data;
                end
            end

            if (step_cmd) ret_step <= 1'b1;
            if (state == SEND_BR && last_done) ret_step <= 1'b0;

            if (load) begin
                o_tx_data <= dump_byte(next_state, dump_idx[1:0], i_stat);
                // PC selector wraps after four bytes
                dump_idx  <= (next_state == SEND_PC)
                             ? {{(NB_DM_ADDR - 2){1'b0}}, dump_idx[1:0] + 2'd1}
                             : dump_idx + 1'b1;
            end
        end
    end

    assign o_ctrl = '{
        run:       (state == START) || (state == STEP_BY_STEP),
        step_flag: (state == STEP_BY_STEP),
        step:      step,
        im_write:  im_write,
        im_addr:   im_addr,
        im_data:   im_data,
        rb_addr:   dump_idx[NB_DM_ADDR-1:2],
        dm_addr:   dump_idx
    };

endmodule

/* design/mini_core.sv */
`timescale 1ns/1ps

module mini_core (
    input  logic                    i_clock,
    input  logic                    i_reset,
    input  dbg_pkg::dbg_core_ctrl_t i_ctrl,
    output dbg_pkg::dbg_core_stat_t o_stat
);
    import dbg_pkg::*;

    logic [NB_DATA-1:0]      imem [IM_BYTES];
    logic [NB_WORD-1:0]      regs [RB_DEPTH];
    logic [NB_DATA-1:0]      dmem [DM_DEPTH];
    logic [NB_WORD-1:0]      pc;
    logic                    halt;
    logic [NB_IM_ADDR-3:0]   word_sel;
    logic [NB_WORD-1:0]      instr;
    logic [NB_OPCODE-1:0]    opcode;
    logic [NB_RB_ADDR-1:0]   rd;
    logic [NB_RB_ADDR-1:0]   rs;
    logic [NB_RB_ADDR-1:0]   rt;
    logic [NB_WORD-1:0]      imm;
    logic [NB_WORD-1:0]      result;
    logic                    exec;

    // Debug load port
    always_ff @(posedge i_clock) begin
        if (i_ctrl.im_write) imem[i_ctrl.im_addr] <= i_ctrl.im_data;
    end

    // Big-endian fetch
    assign word_sel = pc[NB_IM_ADDR-1:2];
    assign instr    = {imem[{word_sel, 2'd0}], imem[{word_sel, 2'd1}],
                       imem[{word_sel, 2'd2}], imem[{word_sel, 2'd3}]};

    assign opcode = instr[31:28];
    assign rd     = instr[27:23];
    assign rs     = instr[22:18];
    assign rt     = instr[17:13];  // Overlaps the immediate
    assign imm    = {{(NB_WORD - 16){instr[15]}}, instr[15:0]};

    assign exec   = i_ctrl.run && !halt && (!i_ctrl.step_flag || i_ctrl.step);
    // Shared adder for ADDI, ADD and the SB address
    assign result = regs[rs] + ((opcode == OP_ADD) ? regs[rt] : imm);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            pc   <= '0;
            halt <= 1'b0;
            for (int i = 0; i < RB_DEPTH; i++) begin
                regs[i] <= '0;
            end
            for (int i = 0; i < DM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (exec) begin
            if (opcode == OP_HALT) begin
                halt <= 1'b1;  // PC parks on the HALT word
            end else begin
                pc <= pc + NB_WORD'(4);
            end
            case (opcode)
                OP_ADDI, OP_ADD: begin
                    if (rd != '0) regs[rd] <= result;  // r0 stays zero
                end
                OP_SB:           dmem[result[NB_DM_ADDR-1:0]] <= regs[rd][NB_DATA-1:0];
                OP_NOP, OP_HALT: ;
                default:         ;  // Unused opcodes behave as NOP
            endcase
        end
    end

    assign o_stat = '{
        pc:      pc,
        halt:    halt,
        rb_data: regs[i_ctrl.rb_addr],
        dm_data: dmem[i_ctrl.dm_addr]
    };

endmodule

/* design/debug_soc.sv */
`timescale 1ns/1ps

module debug_soc (
    input  logic i_clock,
    input  logic i_reset,
    input  logic i_uart_rx,
    output logic o_uart_tx,
    output logic o_halt
);
    import dbg_pkg::*;

    logic [NB_DATA-1:0] rx_data;
    logic               rx_valid;
    logic [NB_DATA-1:0] tx_data;
    logic               tx_start;
    logic               tx_done;
    dbg_core_ctrl_t     core_ctrl;
    dbg_core_stat_t     core_stat;

    uart_rx u_uart_rx (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_serial (i_uart_rx),
        .o_data   (rx_data),
        .o_valid  (rx_valid)
    );

    uart_tx u_uart_tx (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_start  (tx_start),
        .i_data   (tx_data),
        .o_serial (o_uart_tx),
        .o_done   (tx_done)
    );

    debug_unit u_debug_unit (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_rx_valid (rx_valid),
        .i_rx_data  (rx_data),
        .i_tx_done  (tx_done),
        .i_stat     (core_stat),
        .o_tx_start (tx_start),
        .o_tx_data  (tx_data),
        .o_ctrl     (core_ctrl)
    );

    mini_core u_mini_core (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_ctrl  (core_ctrl),
        .o_stat  (core_stat)
    );

    assign o_halt = core_stat.halt;

endmodule

/* verif/debug_soc_checker.sv */
`timescale 1ns/1ps

module debug_soc_checker (
    input logic i_clock,
    input logic i_reset,
    input logic i_serial,
    input logic i_halt
);
    import dbg_pkg::*;

    logic [NB_DATA-1:0] exp_q [$];
    logic [NB_DATA-1:0] rx_byte;
    logic [NB_DATA-1:0] exp_byte;
    int                 rx_count = 0;
    int                 errors = 0;

    task automatic expect_byte(input logic [NB_DATA-1:0] b);
        exp_q.push_back(b);
    endtask

    task automatic check_idle();
        if (i_serial !== 1'b1) begin
            $display("MISMATCH o_uart_tx: expected 1, received %h", i_serial);
            errors++;
        end
        if (i_halt !== 1'b0) begin
            $display("MISMATCH o_halt: expected 0, received %h", i_halt);
            errors++;
        end
    endtask

    // Blocks until every queued byte has come back
    task automatic wait_drained(input int max_cycles);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < max_cycles) begin
            @(negedge i_clock);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d expected bytes were never received on o_uart_tx", exp_q.size());
            errors++;
            exp_q.delete();
        end
    endtask

    task automatic wait_halt(input int max_cycles);
        int n;
        n = 0;
        while (i_halt !== 1'b1 && n < max_cycles) begin
            @(negedge i_clock);
            n++;
        end
        if (i_halt !== 1'b1) begin
            $display("Core never halted within %0d cycles", max_cycles);
            errors++;
        end
    endtask

    // Own 8N1 decoder, sampled on the falling edge
    initial begin
        forever begin
            @(negedge i_clock);
            if (!i_reset && i_serial === 1'b0) begin
                repeat (CLKS_PER_BIT / 2 - 1) @(negedge i_clock);  // Middle of start bit
                for (int i = 0; i < NB_DATA; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge i_clock);
                    rx_byte[i] = i_serial;
                end
                repeat (CLKS_PER_BIT) @(negedge i_clock);
                if (i_serial !== 1'b1) begin
                    $display("Stop bit missing on o_uart_tx at byte %0d", rx_count);
                    errors++;
                end
                if (exp_q.size() == 0) begin
                    $display("Byte %02h arrived on o_uart_tx with nothing expected", rx_byte);
                    errors++;
                end else begin
                    exp_byte = exp_q.pop_front();
                    if (rx_byte !== exp_byte) begin
                        $display("MISMATCH o_uart_tx byte %0d: expected %02h, received %02h",
                                 rx_count, exp_byte, rx_byte);
                        errors++;
                    end
                end
                rx_count++;
            end
        end
    end

endmodule

/* verif/debug_soc_tb.sv */
`timescale 1ns/1ps

module debug_soc_tb;
    import dbg_pkg::*;

    localparam int N_STEPS    = 4;
    localparam int FRAME      = 11 * CLKS_PER_BIT;
    localparam int BYTES_SENT = 149 + N_STEPS;  // Commands, two loads and junk bytes
    localparam int BYTES_EXP  = 132 + 4 + 256 + (N_STEPS + 1) * 260 + 132;
    localparam int LIMIT      = (BYTES_SENT + BYTES_EXP) * FRAME + 5000;

    logic               i_clock;
    logic               i_reset;
    logic               i_uart_rx;
    logic               o_uart_tx;
    logic               o_halt;
    logic [NB_WORD-1:0] prog   [IM_BYTES / 4];
    logic [NB_WORD-1:0] m_regs [RB_DEPTH];  // Reference model state
    logic [NB_DATA-1:0] m_mem  [DM_DEPTH];
    logic [NB_WORD-1:0] m_pc;
    logic               m_halt;
    int                 cycles = 0;
    int                 tests = 0;
    int                 failed = 0;
    int                 err_start = 0;

    debug_soc i_debug_soc (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_uart_rx (i_uart_rx),
        .o_uart_tx (o_uart_tx),
        .o_halt    (o_halt)
    );

    debug_soc_checker u_checker (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_serial (o_uart_tx),
        .i_halt   (o_halt)
    );

    initial begin
        i_clock = 1'b0;
        forever #2 i_clock = ~i_clock;
    end

    always @(posedge i_clock) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("Timeout: run went past %0d cycles", LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    task automatic apply_reset();
        @(posedge i_clock);
        #1 i_reset = 1'b1;
        repeat (16) @(posedge i_clock);
        #1 i_reset = 1'b0;
    endtask

    // 8N1 frame, LSB first
    task automatic send_byte(input logic [NB_DATA-1:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge i_clock);
            #1 i_uart_rx = frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge i_clock);
        end
    endtask

    // Random ADDI, ADD, SB body, then HALT and NOP padding
    task automatic gen_program(input int len);
        logic [NB_OPCODE-1:0] op;
        logic [4:0]           rd;
        logic [4:0]           rs;
        logic [4:0]           rt;
        logic [15:0]          imm;
        for (int k = 0; k < IM_BYTES / 4; k++) begin
            op  = NB_OPCODE'($urandom_range(3, 1));
            rd  = 5'($urandom_range(7));  // Few registers so results chain
            rs  = 5'($urandom_range(7));
            rt  = 5'($urandom_range(7));
            imm = 16'($urandom);
            if (k == len) prog[k] = {OP_HALT, 28'd0};
            else if (k > len) prog[k] = {OP_NOP, 28'd0};
            else if (op == OP_ADD) prog[k] = {op, rd, rs, rt, 13'd0};
            else prog[k] = {op, rd, rs, 2'b00, imm};
        end
    endtask

    task automatic load_program();
        send_byte(CMD_WRITE_IM);
        for (int a = 0; a < IM_BYTES; a++) begin
            send_byte(prog[a / 4][31 - 8 * (a % 4) -: 8]);  // Big-endian words
        end
    endtask

    // Reference model: n instructions from reset, or fewer if HALT comes first
    function automatic void run_model(input int n);
        logic [NB_WORD-1:0] ins;
        logic [NB_WORD-1:0] imm;
        logic [4:0]         rd;
        logic [4:0]         rs;
        m_pc   = '0;
        m_halt = 1'b0;
        foreach (m_regs[i]) m_regs[i] = '0;
        foreach (m_mem[i]) m_mem[i] = '0;
        for (int k = 0; k < n && !m_halt; k++) begin
            ins = prog[m_pc / 4];
            rd  = ins[27:23];
            rs  = ins[22:18];
            imm = {{16{ins[15]}}, ins[15:0]};
            if (ins[31:28] == OP_ADDI && rd != 0) m_regs[rd] = m_regs[rs] + imm;
            if (ins[31:28] == OP_ADD && rd != 0) m_regs[rd] = m_regs[rs] + m_regs[ins[17:13]];
            if (ins[31:28] == OP_SB) m_mem[(m_regs[rs] + imm) % DM_DEPTH] = m_regs[rd][7:0];
            if (ins[31:28] == OP_HALT) m_halt = 1'b1;
            else m_pc = m_pc + 4;
        end
    endfunction

    // Queues the model's dump for a command, sends it and waits for all bytes
    task automatic request_dump(input logic [NB_DATA-1:0] cmd);
        if (cmd == CMD_SEND_PC || cmd == CMD_STEP) begin
            for (int b = 3; b >= 0; b--) u_checker.expect_byte(m_pc[8 * b +: 8]);
        end
        if (cmd == CMD_SEND_MEM || cmd == CMD_STEP) begin
            for (int a = 0; a < DM_DEPTH; a++) u_checker.expect_byte(m_mem[a]);
        end
        if (cmd == CMD_SEND_BR || cmd == CMD_STEP) begin
            for (int r = 0; r < RB_DEPTH; r++) begin
                for (int b = 3; b >= 0; b--) u_checker.expect_byte(m_regs[r][8 * b +: 8]);
            end
        end
        send_byte(cmd);
        u_checker.wait_drained(300 * FRAME);
    endtask

    task automatic end_test(input string name);
        tests++;
        if (u_checker.errors == err_start) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed++;
            $display("test %0d %s: FAIL, %0d errors", tests, name, u_checker.errors - err_start);
        end
        err_start = u_checker.errors;
    endtask

    initial begin
        void'($urandom(96800));
        i_reset   = 1'b1;
        i_uart_rx = 1'b1;  // Line idles high
        apply_reset();

        u_checker.check_idle();
        run_model(0);
        request_dump(CMD_SEND_PC);
        request_dump(CMD_SEND_MEM);
        end_test("reset state and idle dumps");

        gen_program($urandom_range(14, 8));
        load_program();
        send_byte(CMD_START);
        u_checker.wait_halt(2 * FRAME);
        run_model(IM_BYTES / 4);
        request_dump(CMD_SEND_PC);
        end_test("free run to halt");

        request_dump(CMD_SEND_MEM);
        request_dump(CMD_SEND_BR);
        end_test("memory and register dump after run");

        apply_reset();
        gen_program($urandom_range(14, 8));
        load_program();
        send_byte(CMD_STEP_BY_STEP);
        for (int s = 1; s <= N_STEPS; s++) begin
            run_model(s);
            request_dump(CMD_STEP);  // PC, memory and registers after each step
        end
        end_test("single step dumps");

        send_byte(CMD_CONTINUE);
        u_checker.wait_halt(2 * FRAME);
        run_model(IM_BYTES / 4);
        request_dump(CMD_SEND_PC);
        request_dump(CMD_SEND_MEM);
        request_dump(CMD_SEND_BR);
        end_test("continue to halt");

        send_byte(8'h00);
        send_byte(8'h09);
        send_byte(8'hA5);
        send_byte(8'hFF);
        send_byte(CMD_STEP);
        send_byte(CMD_CONTINUE);
        repeat (4 * FRAME) @(posedge i_clock);  // Any stray byte is flagged here
        request_dump(CMD_SEND_PC);
        request_dump(CMD_SEND_MEM);
        end_test("ignored commands");

        $display("%0d tests run, %0d failed, %0d errors", tests, failed, u_checker.errors);
        if (failed == 0 && u_checker.errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* debug_soc.f */
design/dbg_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/debug_unit.sv
design/mini_core.sv
design/debug_soc.sv
verif/debug_soc_checker.sv
verif/debug_soc_tb.sv

/* Bender.yml */
package:
  name: debug_soc

sources:
  - design/dbg_pkg.sv
  - design/uart_rx.sv
  - design/uart_tx.sv
  - design/debug_unit.sv
  - design/mini_core.sv
  - design/debug_soc.sv
  - target: test
    files:
      - verif/debug_soc_checker.sv
      - verif/debug_soc_tb.sv
